// ==== vlog.f ====
rtl/rw_pkg.sv
rtl/sync_fifo.sv
rtl/rw_worker.sv
rtl/rw_cfg_regs.sv
rtl/rw_write_stage.sv
rtl/rw_tile_top.sv
verification/rw_tile_sva.sv
verification/tb_rw_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rw_tile
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_rw_tile.sv ====
`timescale 1ns/10ps

module tb_rw_tile import rw_pkg::*; ();

   localparam int          TILE_ID_TB = 3;
   localparam logic [31:0] BASE       = 32'h0001_0000;
   localparam int          THRESH     = 8;
   localparam int          N_TESTS    = 12;
   localparam int          LIMIT      = N_TESTS * 40 + 50;   // plus reset and config

   typedef struct packed {
      task_type_e ttype;
      locale_t    locale;
      object_t    arg;
      object_t    obj;
      thread_id_t thread;
      cq_slot_t   slot;
      fifo_occ_t  occ;
      logic       gvt_valid;
      cq_slot_t   gvt_slot;
      logic       hold;       // held by the almost-full rule
      logic       has_write;
      object_t    exp_data;
      logic       has_child;
   } entry_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] data;
      logic [STRB_W-1:0] strb;
      thread_id_t        id;
   } wr_exp_t;

   logic clk, rstn;
   logic cfg_req, cfg_ack;
   cfg_bus_t cfg_bus;
   logic task_in_valid, task_in_ready;
   rw_task_t task_in;
   logic wvalid, wready, bvalid, bready;
   logic [ADDR_W-1:0] waddr;
   logic [LINE_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   thread_id_t wid, bid, unlock_thread, resp_id;
   logic task_out_valid, task_out_ready, unlock_locale;
   out_task_t task_out;
   cq_slot_t task_out_cq_slot, gvt_slot, finish_task_slot;
   fifo_occ_t task_out_fifo_occ;
   logic gvt_slot_valid, finish_task_valid, finish_task_ready, finish_task_is_undo;

   entry_t tbl [N_TESTS];
   wr_exp_t wr_q[$];
   out_task_t child_q[$];
   logic [CQ_SLOT_W:0] fin_q[$];   // slot and is_undo
   thread_id_t unlock_q[$];
   cq_slot_t child_slot_q[$];
   logic [31:0] lfsr;
   int errors, checks, cycles, cur, resp_cnt;
   string name;

   rw_tile_top #(.TILE_ID(TILE_ID_TB), .FIFO_LOG_DEPTH(1)) u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic check(input string what, input logic [LINE_W-1:0] exp,
                        input logic [LINE_W-1:0] act);
      checks++;
      assert (exp == act) else begin
         errors++;
         $display("** Error [%s] %s: expected %0h, actual %0h", name, what, exp, act);
      end
   endtask

   // memory model answers each write a few cycles later
   always @(posedge clk) begin
      if (!rstn) begin
         bvalid <= 1'b0;
         resp_cnt <= 0;
      end else begin
         if (bvalid && bready) bvalid <= 1'b0;
         if (wvalid && wready) begin
            resp_id <= wid;
            resp_cnt <= 3;
         end else if (resp_cnt > 1) begin
            resp_cnt <= resp_cnt - 1;
         end else if (resp_cnt == 1 && !bvalid) begin
            bvalid <= 1'b1;
            bid <= resp_id;
            resp_cnt <= 0;
         end
      end
   end

   // random stalls, one lfsr step per bit
   always @(posedge clk) begin
      logic [31:0] s1, s2;
      s1 = lfsr_step(lfsr);
      s2 = lfsr_step(s1);
      lfsr <= s2;
      wready <= s1[0];
      task_out_ready <= s2[0];
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout after %0d cycles in test %0d", cycles, cur);
         $display("Result: FAILED");
         $finish;
      end
   end

   always @(posedge clk) begin
      if (rstn && wvalid && wready) begin
         assert (wr_q.size() > 0) else begin
            errors++;
            $display("unexpected memory write in %s", name);
         end
         if (wr_q.size() > 0) begin
            check("waddr", wr_q[0].addr, waddr);
            check("wdata", wr_q[0].data, wdata);
            check("wstrb", wr_q[0].strb, wstrb);
            check("wid", wr_q[0].id, wid);
            void'(wr_q.pop_front());
         end
      end
      if (rstn && task_out_valid && task_out_ready) begin
         assert (child_q.size() > 0) else begin
            errors++;
            $display("unexpected child task in %s", name);
         end
         if (child_q.size() > 0) begin
            check("child", child_q.pop_front(), task_out);
            check("child slot", child_slot_q.pop_front(), task_out_cq_slot);
         end
      end
      if (rstn && finish_task_valid && finish_task_ready) begin
         assert (fin_q.size() > 0) else begin
            errors++;
            $display("unexpected finish in %s", name);
         end
         if (fin_q.size() > 0) check("finish", fin_q.pop_front(),
                                     {finish_task_slot, finish_task_is_undo});
      end
      if (rstn && unlock_locale) begin
         assert (unlock_q.size() > 0) else begin
            errors++;
            $display("unexpected unlock in %s", name);
         end
         if (unlock_q.size() > 0) check("unlock thread", unlock_q.pop_front(), unlock_thread);
      end
      // a read taken this cycle holds off the write response
      if (rstn) begin
         check("bready", !(task_in_valid && task_in_ready &&
                           task_in.task_desc.ttype == TT_READ), bready);
      end
   end

   task automatic cfg_write(input cfg_addr_e addr, input logic [31:0] data);
      @(posedge clk);
      cfg_bus <= '{cfg_addr: addr, wdata: data};
      cfg_req <= 1'b1;
      do @(posedge clk); while (!cfg_ack);
      cfg_req <= 1'b0;
      do @(posedge clk); while (cfg_ack);
   endtask

   task automatic expect_entry(input entry_t e, inout spawn_seq_t seq);
      wr_exp_t w;
      out_task_t c;
      if (e.has_write) begin
         w.addr = BASE + {e.locale, 2'b00};
         w.data = LINE_W'(e.exp_data) << (e.locale[3:0] * 32);
         w.strb = STRB_W'(4'hf) << (e.locale[3:0] * 4);
         w.id   = e.thread;
         wr_q.push_back(w);
      end
      if (e.has_child) begin
         c.task_desc = '{ttype: TT_WRITE, locale: e.locale + 16'd1, arg: e.exp_data};
         c.tile = TILE_ID_TB;
         c.seq = seq;
         seq++;
         child_q.push_back(c);
         child_slot_q.push_back(e.slot);
      end else begin
         fin_q.push_back({e.slot, e.ttype == TT_UNDO_RESTORE});
      end
      unlock_q.push_back(e.thread);
   endtask

   initial begin
      spawn_seq_t seq;
      entry_t e;
      lfsr = 32'h027b_a277;
      errors = 0;
      checks = 0;
      cycles = 0;
      cur = -1;
      seq = '0;
      name = "reset";
      rstn = 1'b0;
      cfg_req = 1'b0;
      cfg_bus = '0;
      task_in_valid = 1'b0;
      task_in = '0;
      wready = 1'b0;
      bvalid = 1'b0;
      bid = '0;
      task_out_ready = 1'b0;
      task_out_fifo_occ = '0;
      gvt_slot_valid = 1'b0;
      gvt_slot = '0;
      finish_task_ready = 1'b1;
      //        type  locale arg  obj  thr slot occ gvt/slot hold w data child
      tbl[0]  = '{TT_WRITE, 16'h0005, 32'h1111_2222, 32'h0, 4'd1, 6'd1, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b1, 32'h1111_2222, 1'b0};
      tbl[1]  = '{TT_INCR, 16'h0013, 32'h5, 32'h100, 4'd2, 6'd2, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b1, 32'h105, 1'b1};
      tbl[2]  = '{TT_READ, 16'h0007, 32'h0, 32'h0, 4'd3, 6'd3, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b0, 32'h0, 1'b0};
      tbl[3]  = '{TT_UNDO_RESTORE, 16'h000f, 32'h0, 32'hdead_beef, 4'd4, 6'd4, 5'd0, 1'b0,
                  6'd0, 1'b0, 1'b1, 32'hdead_beef, 1'b0};
      tbl[4]  = '{TT_WRITE, 16'h0008, 32'h0a0b_0c0d, 32'h0, 4'd5, 6'd5, 5'd12, 1'b1, 6'd9,
                  1'b1, 1'b1, 32'h0a0b_0c0d, 1'b0};   // held
      tbl[5]  = '{TT_INCR, 16'h0040, 32'h2, 32'h7, 4'd6, 6'd6, 5'd12, 1'b1, 6'd6,
                  1'b0, 1'b1, 32'h9, 1'b1};           // gvt bypass
      tbl[6]  = '{TT_READ, 16'h0011, 32'h0, 32'h0, 4'd7, 6'd7, 5'd8, 1'b0, 6'd0,
                  1'b1, 1'b0, 32'h0, 1'b0};           // occupancy at threshold
      tbl[7]  = '{TT_INCR, 16'hffff, 32'h1, 32'hffff_ffff, 4'd8, 6'd8, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b1, 32'h0, 1'b1};
      tbl[8]  = '{TT_UNDO_RESTORE, 16'h0020, 32'h0, 32'h1234_5678, 4'd9, 6'd9, 5'd0, 1'b0,
                  6'd0, 1'b0, 1'b1, 32'h1234_5678, 1'b0};
      tbl[9]  = '{TT_WRITE, 16'h002a, 32'hcafe_f00d, 32'h0, 4'd10, 6'd10, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b1, 32'hcafe_f00d, 1'b0};
      tbl[10] = '{TT_INCR, 16'h0101, 32'h10, 32'h20, 4'd11, 6'd11, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b1, 32'h30, 1'b1};
      tbl[11] = '{TT_READ, 16'h0003, 32'h0, 32'h0, 4'd12, 6'd12, 5'd0, 1'b0, 6'd0,
                  1'b0, 1'b0, 32'h0, 1'b0};
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      name = "config";
      cfg_write(CFG_RW_BASE, BASE);
      cfg_write(CFG_FIFO_THRESH, THRESH);
      for (int i = 0; i < N_TESTS; i++) begin
         e = tbl[i];
         cur = i;
         name = $sformatf("t%0d_%s", i, e.ttype.name());
         expect_entry(e, seq);
         @(posedge clk);
         task_in <= '{task_desc: '{ttype: e.ttype, locale: e.locale, arg: e.arg},
                      object: e.obj, thread: e.thread, cq_slot: e.slot};
         task_in_valid <= 1'b1;
         task_out_fifo_occ <= e.occ;
         gvt_slot_valid <= e.gvt_valid;
         gvt_slot <= e.gvt_slot;
         if (e.hold) begin
            repeat (4) begin
               @(posedge clk);
               check("held ready", 1'b0, task_in_ready);
            end
            task_out_fifo_occ <= '0;   // release
         end
         do @(posedge clk); while (!task_in_ready);
         task_in_valid <= 1'b0;
         while (wr_q.size() || child_q.size() || fin_q.size() || unlock_q.size())
            @(posedge clk);
      end
      repeat (4) @(posedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/rw_tile_sva.sv ====
`timescale 1ns/10ps

module rw_tile_sva import rw_pkg::*; (
   input logic              clk,
   input logic              rstn,
   input logic              cfg_req,
   input logic              cfg_ack,
   input logic              wvalid,
   input logic              wready,
   input logic [ADDR_W-1:0] waddr,
   input logic [LINE_W-1:0] wdata,
   input logic              task_out_valid,
   input logic              task_out_ready,
   input out_task_t         task_out,
   input logic              unlock_locale
);

   // memory write holds until taken
   wr_stable: assert property (@(posedge clk) disable iff (!rstn)
      wvalid && !wready |=> wvalid && $stable(waddr) && $stable(wdata))
      else $error("memory write changed before wready");

   out_stable: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out))
      else $error("child task changed before task_out_ready");

   ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
      $rose(cfg_ack) |-> $past(cfg_req))
      else $error("cfg_ack rose without cfg_req");

   unlock_pulse: assert property (@(posedge clk) disable iff (!rstn)
      unlock_locale |=> !unlock_locale)
      else $error("unlock_locale longer than one cycle");

endmodule

bind rw_tile_top rw_tile_sva u_sva (.*);

// ==== rtl/rw_tile_top.sv ====
`timescale 1ns/10ps

module rw_tile_top import rw_pkg::*; #(
   parameter int TILE_ID        = 0,
   parameter int FIFO_LOG_DEPTH = 1
) (
   input  logic              clk,
   input  logic              rstn,

   input  logic              cfg_req,
   output logic              cfg_ack,
   input  cfg_bus_t          cfg_bus,

   input  logic              task_in_valid,
   output logic              task_in_ready,
   input  rw_task_t          task_in,

   output logic              wvalid,
   input  logic              wready,
   output logic [ADDR_W-1:0] waddr,
   output logic [LINE_W-1:0] wdata,
   output logic [STRB_W-1:0] wstrb,
   output thread_id_t        wid,

   input  logic              bvalid,
   output logic              bready,
   input  thread_id_t        bid,

   output logic              task_out_valid,
   input  logic              task_out_ready,
   output out_task_t         task_out,
   output cq_slot_t          task_out_cq_slot,

   input  fifo_occ_t         task_out_fifo_occ,
   input  logic              gvt_slot_valid,
   input  cq_slot_t          gvt_slot,

   output logic              unlock_locale,
   output thread_id_t        unlock_thread,

   output logic              finish_task_valid,
   input  logic              finish_task_ready,
   output cq_slot_t          finish_task_slot,
   output logic              finish_task_is_undo
);

   logic [31:0] rw_base;
   fifo_occ_t   fifo_thresh;

   rw_cfg_regs u_cfg (
      .clk        (clk),
      .rstn       (rstn),
      .cfg_req    (cfg_req),
      .cfg_bus    (cfg_bus),
      .cfg_ack    (cfg_ack),
      .rw_base    (rw_base),
      .fifo_thresh(fifo_thresh)
   );

   rw_write_stage #(
      .TILE_ID       (TILE_ID),
      .FIFO_LOG_DEPTH(FIFO_LOG_DEPTH)
   ) u_write_stage (
      .clk                (clk),
      .rstn               (rstn),
      .task_in_valid      (task_in_valid),
      .task_in_ready      (task_in_ready),
      .task_in            (task_in),
      .wvalid             (wvalid),
      .wready             (wready),
      .waddr              (waddr),
      .wdata              (wdata),
      .wstrb              (wstrb),
      .wid                (wid),
      .bvalid             (bvalid),
      .bready             (bready),
      .bid                (bid),
      .task_out_valid     (task_out_valid),
      .task_out_ready     (task_out_ready),
      .task_out           (task_out),
      .task_out_cq_slot   (task_out_cq_slot),
      .task_out_fifo_occ  (task_out_fifo_occ),
      .gvt_slot_valid     (gvt_slot_valid),
      .gvt_slot           (gvt_slot),
      .unlock_locale      (unlock_locale),
      .unlock_thread      (unlock_thread),
      .finish_task_valid  (finish_task_valid),
      .finish_task_ready  (finish_task_ready),
      .finish_task_slot   (finish_task_slot),
      .finish_task_is_undo(finish_task_is_undo),
      .rw_base            (rw_base),
      .fifo_thresh        (fifo_thresh)
   );

endmodule

// ==== rtl/rw_write_stage.sv ====
`timescale 1ns/10ps

module rw_write_stage import rw_pkg::*; #(
   parameter int TILE_ID        = 0,
   parameter int FIFO_LOG_DEPTH = 1
) (
   input  logic              clk,
   input  logic              rstn,

   input  logic              task_in_valid,
   output logic              task_in_ready,
   input  rw_task_t          task_in,

   output logic              wvalid,
   input  logic              wready,
   output logic [ADDR_W-1:0] waddr,
   output logic [LINE_W-1:0] wdata,
   output logic [STRB_W-1:0] wstrb,
   output thread_id_t        wid,

   input  logic              bvalid,
   output logic              bready,
   input  thread_id_t        bid,

   output logic              task_out_valid,
   input  logic              task_out_ready,
   output out_task_t         task_out,
   output cq_slot_t          task_out_cq_slot,

   input  fifo_occ_t         task_out_fifo_occ,
   input  logic              gvt_slot_valid,
   input  cq_slot_t          gvt_slot,

   output logic              unlock_locale,
   output thread_id_t        unlock_thread,

   output logic              finish_task_valid,
   input  logic              finish_task_ready,
   output cq_slot_t          finish_task_slot,
   output logic              finish_task_is_undo,

   input  logic [31:0]       rw_base,
   input  fifo_occ_t         fifo_thresh
);

   typedef struct packed {
      thread_id_t thread;
      locale_t    locale;
      object_t    obj;
   } wr_entry_t;

   typedef struct packed {
      cq_slot_t slot;
      logic     is_undo;
   } fin_entry_t;

   logic       is_undo;
   logic       thresh_ok;
   logic       w_wvalid, w_out_valid;
   object_t    w_wdata;
   out_task_t  w_out_task;
   logic       need_write, need_out, need_finish;
   logic       out_ready;
   logic       accept;
   logic       nowrite_unlock;
   wr_entry_t  wr_in, wr_head;
   fin_entry_t fin_in, fin_head;
   logic       wfifo_full, wfifo_empty;
   logic       ffifo_full, ffifo_empty;

   assign is_undo   = (task_in.task_desc.ttype == TT_UNDO_RESTORE);
   // almost-full rule, the gvt task always gets through
   assign thresh_ok = (task_out_fifo_occ < fifo_thresh) ||
                      (gvt_slot_valid && (gvt_slot == task_in.cq_slot));

   rw_worker #(
      .TILE_ID(TILE_ID)
   ) u_worker (
      .clk        (clk),
      .rstn       (rstn),
      .in_valid   (task_in_valid && !is_undo),
      .in_desc    (task_in.task_desc),
      .in_object  (task_in.object),
      .sched_ready(task_in_ready),
      .wvalid     (w_wvalid),
      .wdata      (w_wdata),
      .out_valid  (w_out_valid),
      .out_task   (w_out_task)
   );

   assign need_write  = is_undo || w_wvalid;
   assign need_out    = !is_undo && w_out_valid;
   assign need_finish = !need_out;
   assign out_ready   = !task_out_valid || task_out_ready;

   assign task_in_ready = thresh_ok &&
                          (!need_write || !wfifo_full) &&
                          (!need_out || out_ready) &&
                          (!need_finish || !ffifo_full);
   assign accept        = task_in_valid && task_in_ready;

   assign wr_in.thread = task_in.thread;
   assign wr_in.locale = task_in.task_desc.locale;
   assign wr_in.obj    = is_undo ? task_in.object : w_wdata;   // restore bypasses worker

   sync_fifo #(
      .WIDTH    ($bits(wr_entry_t)),
      .LOG_DEPTH(FIFO_LOG_DEPTH)
   ) u_wr_fifo (
      .clk    (clk),
      .rstn   (rstn),
      .wr_en  (accept && need_write),
      .wr_data(wr_in),
      .rd_en  (wvalid && wready),
      .rd_data(wr_head),
      .full   (wfifo_full),
      .empty  (wfifo_empty)
   );

   assign wvalid = !wfifo_empty;
   assign wid    = wr_head.thread;
   assign waddr  = rw_base + {{(ADDR_W-LOCALE_W-2){1'b0}}, wr_head.locale, 2'b00};

   always_comb begin
      wdata = '0;
      wstrb = '0;
      wdata[wr_head.locale[LANE_SEL_W-1:0]*OBJ_W +: OBJ_W]     = wr_head.obj;
      wstrb[wr_head.locale[LANE_SEL_W-1:0]*(OBJ_W/8) +: OBJ_W/8] = '1;
   end

   // registered child output
   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_out_valid <= 1'b0;
      end else if (accept && need_out) begin
         task_out_valid <= 1'b1;
      end else if (task_out_ready) begin
         task_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && need_out) begin
         task_out         <= w_out_task;
         task_out_cq_slot <= task_in.cq_slot;
      end
   end

   assign fin_in.slot    = task_in.cq_slot;
   assign fin_in.is_undo = is_undo;

   sync_fifo #(
      .WIDTH    ($bits(fin_entry_t)),
      .LOG_DEPTH(FIFO_LOG_DEPTH)
   ) u_fin_fifo (
      .clk    (clk),
      .rstn   (rstn),
      .wr_en  (accept && need_finish),
      .wr_data(fin_in),
      .rd_en  (finish_task_valid && finish_task_ready),
      .rd_data(fin_head),
      .full   (ffifo_full),
      .empty  (ffifo_empty)
   );

   assign finish_task_valid   = !ffifo_empty;
   assign finish_task_slot    = fin_head.slot;
   assign finish_task_is_undo = fin_head.is_undo;

   // a task with no write unlocks now, the response waits one cycle
   assign nowrite_unlock = accept && !need_write;
   assign bready         = !nowrite_unlock;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         unlock_locale <= 1'b0;
      end else begin
         unlock_locale <= nowrite_unlock || bvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (nowrite_unlock) begin
         unlock_thread <= task_in.thread;
      end else if (bvalid) begin
         unlock_thread <= bid;
      end
   end

endmodule

// ==== rtl/rw_cfg_regs.sv ====
`timescale 1ns/10ps

module rw_cfg_regs import rw_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        cfg_req,
   input  cfg_bus_t    cfg_bus,
   output logic        cfg_ack,
   output logic [31:0] rw_base,
   output fifo_occ_t   fifo_thresh
);

   logic do_write;

   assign do_write = cfg_req && !cfg_ack;   // first cycle of a new request

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg_ack <= 1'b0;
      end else if (do_write) begin
         cfg_ack <= 1'b1;
      end else if (!cfg_req) begin
         cfg_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rw_base     <= '0;
         fifo_thresh <= '1;
      end else if (do_write) begin
         case (cfg_bus.cfg_addr)
            CFG_RW_BASE: begin
               rw_base <= {cfg_bus.wdata[31:2], 2'b00};   // word aligned
            end
            CFG_FIFO_THRESH: begin
               fifo_thresh <= cfg_bus.wdata[FIFO_OCC_W-1:0];
            end
         endcase
      end
   end

endmodule

// ==== rtl/rw_worker.sv ====
`timescale 1ns/10ps

module rw_worker import rw_pkg::*; #(
   parameter int TILE_ID = 0
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       in_valid,
   input  task_desc_t in_desc,
   input  object_t    in_object,
   input  logic       sched_ready,
   output logic       wvalid,
   output object_t    wdata,
   output logic       out_valid,
   output out_task_t  out_task
);

   spawn_seq_t seq_q;
   object_t    incr_val;

   assign incr_val = in_object + in_desc.arg;

   always_comb begin
      wvalid    = 1'b0;
      wdata     = '0;
      out_valid = 1'b0;
      out_task  = '0;
      if (in_valid) begin
         case (in_desc.ttype)
            TT_WRITE: begin
               wvalid = 1'b1;
               wdata  = in_desc.arg;
            end
            TT_INCR: begin
               wvalid    = 1'b1;
               wdata     = incr_val;
               // child writes the new value into the next object
               out_valid = 1'b1;
               out_task.task_desc.ttype  = TT_WRITE;
               out_task.task_desc.locale = in_desc.locale + 1'b1;
               out_task.task_desc.arg    = incr_val;
               out_task.tile             = tile_id_t'(TILE_ID);
               out_task.seq              = seq_q;
            end
            default: begin
               // reads write nothing, restores never reach the worker
               wvalid    = 1'b0;
               out_valid = 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         seq_q <= '0;
      end else if (in_valid && out_valid && sched_ready) begin
         seq_q <= seq_q + 1'b1;   // one per accepted child
      end
   end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
   parameter int WIDTH     = 8,
   parameter int LOG_DEPTH = 1
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             empty
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   logic [WIDTH-1:0]   mem [DEPTH];
   logic [LOG_DEPTH:0] wr_ptr;   // msb is the wrap bit
   logic [LOG_DEPTH:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && !full) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];
   assign empty   = (wr_ptr == rd_ptr);
   assign full    = (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]) &&
                    (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]);

endmodule

// ==== rtl/rw_pkg.sv ====
package rw_pkg;

   localparam int LOCALE_W   = 16;
   localparam int OBJ_W      = 32;
   localparam int THREAD_W   = 4;
   localparam int CQ_SLOT_W  = 6;
   localparam int FIFO_OCC_W = 5;
   localparam int TILE_W     = 8;
   localparam int SEQ_W      = 16;
   localparam int ADDR_W     = 32;
   localparam int LINE_W     = 512;           // one data line
   localparam int STRB_W     = LINE_W / 8;
   localparam int LANE_SEL_W = 4;             // 16 object lanes per line

   typedef enum logic [1:0] {
      TT_WRITE        = 2'd0,
      TT_INCR         = 2'd1,
      TT_READ         = 2'd2,
      TT_UNDO_RESTORE = 2'd3
   } task_type_e;

   typedef logic [LOCALE_W-1:0]   locale_t;
   typedef logic [OBJ_W-1:0]      object_t;
   typedef logic [THREAD_W-1:0]   thread_id_t;
   typedef logic [CQ_SLOT_W-1:0]  cq_slot_t;
   typedef logic [FIFO_OCC_W-1:0] fifo_occ_t;
   typedef logic [TILE_W-1:0]     tile_id_t;
   typedef logic [SEQ_W-1:0]      spawn_seq_t;

   typedef struct packed {
      task_type_e         ttype;
      locale_t            locale;
      logic [OBJ_W-1:0]   arg;
   } task_desc_t;

   typedef struct packed {
      task_desc_t task_desc;
      object_t    object;
      thread_id_t thread;
      cq_slot_t   cq_slot;
   } rw_task_t;

   // child task as it leaves the tile
   typedef struct packed {
      task_desc_t task_desc;
      tile_id_t   tile;
      spawn_seq_t seq;
   } out_task_t;

   typedef enum logic {
      CFG_RW_BASE     = 1'b0,
      CFG_FIFO_THRESH = 1'b1
   } cfg_addr_e;

   typedef struct packed {
      cfg_addr_e    cfg_addr;
      logic [31:0]  wdata;
   } cfg_bus_t;

endpackage
